// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := controllerTb
FILELIST := sources.f
OBJDIR   := obj_dir

.PHONY: sim clean

# Pass only if the run prints the pass line
sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== common/ctrlPkg.sv ====
//////////////////////////////////////////////////
// Shared definitions for the RV32I controller
// Opcodes, field constants, control enums and the
// per-stage control structs used by all RTL files
//////////////////////////////////////////////////

`default_nettype none

package ctrlPkg;

  //////////////////////////////////////////////////
  // Widths and field constants
  //////////////////////////////////////////////////

  localparam int InstrWidth  = 32;            // Instruction width
  localparam int Funct3Width = 3;             // Funct3 field width

  localparam logic [6:0] Funct7Zero = 7'b0000000;  // Base R-type, srli, slli
  localparam logic [6:0] Funct7Alt  = 7'b0100000;  // sub, sra, srai

  localparam int MemReadBit  = 1;             // memRw[1] set for loads
  localparam int MemWriteBit = 0;             // memRw[0] set for stores

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // RV32I major opcodes
  typedef enum logic [6:0] {
    opLoad    = 7'b0000011,
    opMiscMem = 7'b0001111,                   // fence
    opOpImm   = 7'b0010011,
    opAuipc   = 7'b0010111,
    opStore   = 7'b0100011,
    opOp      = 7'b0110011,
    opLui     = 7'b0110111,
    opBranch  = 7'b1100011,
    opJalr    = 7'b1100111,
    opJal     = 7'b1101111
  } opcodeT;

  // Immediate formats in the encoding of the datapath extender
  typedef enum logic [2:0] {
    iType = 3'b000,
    sType = 3'b001,
    bType = 3'b010,
    jType = 3'b011,
    uType = 3'b100
  } immSrcT;

  // Write-back source select
  typedef enum logic [2:0] {
    resAlu = 3'b000,
    resMem = 3'b001
  } resultSrcT;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic rsvd;                               // Word-op bit that RV32 keeps at zero
    logic subArith;                           // Subtract, sra, slt, sltu
    logic aluOp;                              // Use funct3 for the operation
  } aluCtrlT;

  typedef struct packed {
    logic eq;                                 // Operands equal
    logic lt;                                 // rs1 less than rs2
  } branchFlagsT;

  typedef struct packed {
    logic       regWrite;
    immSrcT     immSrc;
    logic       aluSrcA;                      // PC as operand A
    logic       aluSrcB;                      // Immediate as operand B
    logic [1:0] memRw;                        // {read, write}
    resultSrcT  resultSrc;
    logic       branch;
    logic       aluOp;
    logic       jump;
    logic       aluResultSrc;                 // Pass operand B (lui) or PC+4 (jumps)
    logic       fence;
    logic       illegal;
  } decodeCtrlT;

  typedef struct packed {
    logic                   regWrite;
    resultSrcT              resultSrc;
    logic [1:0]             memRw;
    logic                   jump;
    logic                   branch;
    aluCtrlT                aluControl;
    logic                   aluSrcA;
    logic                   aluSrcB;
    logic                   aluResultSrc;
    logic [Funct3Width-1:0] funct3;
    logic                   instrValid;
  } execCtrlT;

  typedef struct packed {
    logic                   regWrite;
    resultSrcT              resultSrc;
    logic [1:0]             memRw;
    logic [Funct3Width-1:0] funct3;           // Access size and sign for the LSU
    logic                   instrValid;
  } memCtrlT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
  } wbCtrlT;

endpackage

`default_nettype wire

// ==== decode/aluDecoder.sv ====
//////////////////////////////////////////////////
// ALU operation decoder
// Adds the subArith bit to the ALU-op class using
// funct3, funct7 bit 5 and opcode bit 5
//////////////////////////////////////////////////

`default_nettype none

module aluDecoder (
  input  logic                            aluOp,     // Use funct3, else plain add
  input  logic [ctrlPkg::Funct3Width-1:0] funct3,
  input  logic                            funct7b5,
  input  logic                            opb5,      // R-type, not immediate
  output ctrlPkg::aluCtrlT                aluControl
);

  logic isSub;                                // R-type subtract
  logic isSra;                                // sra and srai
  logic isSlt;                                // slt and slti
  logic isSltu;                               // sltu and sltiu

  // Funct7 bit 5 alone picks the alternate op since the main decoder rejects the rest
  assign isSub  = (funct3 == 3'b000) & funct7b5 & opb5;  // addi has no sub form
  assign isSra  = (funct3 == 3'b101) & funct7b5;
  assign isSlt  = (funct3 == 3'b010);
  assign isSltu = (funct3 == 3'b011);

  assign aluControl.rsvd     = 1'b0;          // No word ops in RV32
  assign aluControl.subArith = aluOp & (isSub | isSra | isSlt | isSltu);
  assign aluControl.aluOp    = aluOp;

endmodule

`default_nettype wire

// ==== decode/instrDecoder.sv ====
//////////////////////////////////////////////////
// Main instruction decoder for the Decode stage
// Checks funct legality, then looks up the control
// bundle by opcode. StrictDecode picks exact or
// cheap funct checking
//////////////////////////////////////////////////

`default_nettype none

module instrDecoder #(
  parameter bit StrictDecode = 1'b1
) (
  input  logic [ctrlPkg::InstrWidth-1:0]  instr,
  output ctrlPkg::decodeCtrlT             ctrl,
  output logic [ctrlPkg::Funct3Width-1:0] funct3,
  output logic                            funct7b5,
  output logic                            opb5
);

  ctrlPkg::opcodeT opcode;                    // Major opcode
  logic [6:0]      funct7;                    // Upper funct field
  logic            iFunct, rFunct;            // Legal I-type ALU, R-type
  logic            lFunct, sFunct;            // Legal load, store
  logic            bFunct, jFunct;            // Legal branch, jalr

  // Field extraction
  assign opcode   = ctrlPkg::opcodeT'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign funct7b5 = instr[30];
  assign opb5     = instr[5];                 // Separates R-type from I-type ALU

  //////////////////////////////////////////////////
  // Funct legality
  //////////////////////////////////////////////////

  if (StrictDecode) begin : gStrict
    logic f7Zero, f7Alt;                      // Exact funct7 matches
    logic iShift, iNoShift;

    assign f7Zero   = (funct7 == ctrlPkg::Funct7Zero);
    assign f7Alt    = (funct7 == ctrlPkg::Funct7Alt);
    assign iShift   = ((funct3 == 3'b001) & f7Zero) |
                      ((funct3 == 3'b101) & (f7Zero | f7Alt));  // slli, srli, srai
    assign iNoShift = (funct3 != 3'b001) & (funct3 != 3'b101);
    assign iFunct   = iShift | iNoShift;
    assign rFunct   = (((funct3 == 3'b000) | (funct3 == 3'b101)) & f7Alt) | f7Zero;
    assign lFunct   = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010) |
                      (funct3 == 3'b100) | (funct3 == 3'b101);  // lb lh lw lbu lhu
    assign sFunct   = (funct3 == 3'b000) | (funct3 == 3'b001) |
                      (funct3 == 3'b010);     // sb sh sw
    assign bFunct   = (funct3[2:1] != 2'b01); // No 010, 011 branches
    assign jFunct   = (funct3 == 3'b000);
  end else begin : gCheap
    assign iFunct = 1'b1;
    assign rFunct = ~funct7[0];               // Rejects the M-extension space only
    assign lFunct = 1'b1;
    assign sFunct = 1'b1;
    assign bFunct = 1'b1;
    assign jFunct = 1'b1;
  end

  //////////////////////////////////////////////////
  // Opcode table
  //////////////////////////////////////////////////

  always_comb begin
    ctrl         = '0;
    ctrl.illegal = 1'b1;                      // Unknown opcode or bad funct
    unique case (opcode)
      ctrlPkg::opLoad: if (lFunct) begin
        ctrl.illegal   = 1'b0;
        ctrl.regWrite  = 1'b1;
        ctrl.immSrc    = ctrlPkg::iType;
        ctrl.aluSrcB   = 1'b1;                // Base plus offset
        ctrl.memRw     = 2'b10;
        ctrl.resultSrc = ctrlPkg::resMem;
      end
      ctrlPkg::opMiscMem: begin
        ctrl.illegal = 1'b0;                  // Memory is in order, so a no-op
        ctrl.fence   = 1'b1;
      end
      ctrlPkg::opOpImm: if (iFunct) begin
        ctrl.illegal  = 1'b0;
        ctrl.regWrite = 1'b1;
        ctrl.immSrc   = ctrlPkg::iType;
        ctrl.aluSrcB  = 1'b1;
        ctrl.aluOp    = 1'b1;
      end
      ctrlPkg::opAuipc: begin
        ctrl.illegal  = 1'b0;
        ctrl.regWrite = 1'b1;
        ctrl.immSrc   = ctrlPkg::uType;
        ctrl.aluSrcA  = 1'b1;                 // PC plus upper immediate
        ctrl.aluSrcB  = 1'b1;
      end
      ctrlPkg::opStore: if (sFunct) begin
        ctrl.illegal = 1'b0;
        ctrl.immSrc  = ctrlPkg::sType;
        ctrl.aluSrcB = 1'b1;
        ctrl.memRw   = 2'b01;
      end
      ctrlPkg::opOp: if (rFunct) begin
        ctrl.illegal  = 1'b0;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = 1'b1;
      end
      ctrlPkg::opLui: begin
        ctrl.illegal      = 1'b0;
        ctrl.regWrite     = 1'b1;
        ctrl.immSrc       = ctrlPkg::uType;
        ctrl.aluSrcB      = 1'b1;
        ctrl.aluResultSrc = 1'b1;             // Immediate straight through
      end
      ctrlPkg::opBranch: if (bFunct) begin
        ctrl.illegal = 1'b0;
        ctrl.immSrc  = ctrlPkg::bType;
        ctrl.aluSrcA = 1'b1;                  // Target is PC plus offset
        ctrl.aluSrcB = 1'b1;
        ctrl.branch  = 1'b1;
      end
      ctrlPkg::opJalr: if (jFunct) begin
        ctrl.illegal      = 1'b0;
        ctrl.regWrite     = 1'b1;
        ctrl.immSrc       = ctrlPkg::iType;
        ctrl.aluSrcB      = 1'b1;
        ctrl.jump         = 1'b1;
        ctrl.aluResultSrc = 1'b1;             // Link value
      end
      ctrlPkg::opJal: begin
        ctrl.illegal      = 1'b0;
        ctrl.regWrite     = 1'b1;
        ctrl.immSrc       = ctrlPkg::jType;
        ctrl.aluSrcA      = 1'b1;
        ctrl.aluSrcB      = 1'b1;
        ctrl.jump         = 1'b1;
        ctrl.aluResultSrc = 1'b1;
      end
      default: ;                              // Keep the illegal default
    endcase
  end

endmodule

`default_nettype wire

// ==== source/branchUnit.sv ====
//////////////////////////////////////////////////
// Execute-stage branch resolution
// Picks eq or lt by funct3, inverts for bne, bge
// and bgeu, and forms the next-PC select
//////////////////////////////////////////////////

`default_nettype none

module branchUnit (
  input  ctrlPkg::branchFlagsT            flags,     // From the comparator
  input  logic [ctrlPkg::Funct3Width-1:0] funct3,
  input  logic                            jump,
  input  logic                            branch,
  output logic                            pcSrc,     // Take target PC
  output logic                            branchSigned
);

  logic flagSel;                              // Flag chosen by funct3[2]
  logic taken;                                // Condition holds

  // beq/bne use eq, the rest use lt
  assign flagSel = funct3[2] ? flags.lt : flags.eq;
  assign taken   = flagSel ^ funct3[0];       // Odd funct3 is the inverse test
  assign pcSrc   = jump | (branch & taken);

  // bltu and bgeu compare unsigned
  assign branchSigned = ~(funct3[2:1] == 2'b11);

endmodule

`default_nettype wire

// ==== source/controller.sv ====
//////////////////////////////////////////////////
// Top of the RV32I instruction controller
// Decodes in D, carries control through E, M and W
// under hazard-unit stall and flush, resolves
// branches in E and raises the store stall
//////////////////////////////////////////////////

`default_nettype none

module controller #(
  parameter bit StrictDecode    = 1'b1,       // Exact funct checking
  parameter bit DcacheSupported = 1'b1        // Store then store also stalls
) (
  input  logic                           clk,
  input  logic                           arstN,
  // Decode
  input  logic                           stallD,
  input  logic                           flushD,
  input  logic [ctrlPkg::InstrWidth-1:0] instrD,
  output ctrlPkg::immSrcT                immSrcD,
  output logic                           illegalInstrD,
  output logic                           jumpD,
  output logic                           branchD,
  output logic                           instrValidD,
  output logic                           storeStallD,
  // Execute
  input  logic                           stallE,
  input  logic                           flushE,
  input  ctrlPkg::branchFlagsT           flagsE,
  output ctrlPkg::execCtrlT              execE,
  output logic                           pcSrcE,
  output logic                           branchSignedE,
  // Memory
  input  logic                           stallM,
  input  logic                           flushM,
  output ctrlPkg::memCtrlT               memM,
  // Writeback
  input  logic                           stallW,
  input  logic                           flushW,
  output ctrlPkg::wbCtrlT                wbW
);

  ctrlPkg::decodeCtrlT             ctrlD;     // Main decoder bundle
  logic [ctrlPkg::Funct3Width-1:0] funct3D;
  logic                            funct7b5D;
  logic                            opb5D;
  ctrlPkg::aluCtrlT                aluControlD;
  ctrlPkg::execCtrlT               execD;     // Next Execute payload
  ctrlPkg::memCtrlT                memE;      // Next Memory payload
  ctrlPkg::wbCtrlT                 wbM;       // Next Writeback payload

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  instrDecoder #(.StrictDecode(StrictDecode)) mainDecoderD (
    .instr(instrD), .ctrl(ctrlD), .funct3(funct3D), .funct7b5(funct7b5D), .opb5(opb5D)
  );

  aluDecoder aluDecoderD (
    .aluOp(ctrlD.aluOp), .funct3(funct3D), .funct7b5(funct7b5D), .opb5(opb5D),
    .aluControl(aluControlD)
  );

  assign immSrcD       = ctrlD.immSrc;
  assign illegalInstrD = ctrlD.illegal;
  assign jumpD         = ctrlD.jump;
  assign branchD       = ctrlD.branch;

  // Low after reset or a D flush until the next fetch arrives
  ctrlStageReg #(.PayloadT(logic)) validRegD (
    .clk(clk), .arstN(arstN), .flush(flushD), .stall(stallD), .d(1'b1), .q(instrValidD)
  );

  // Store in E blocks a load after it, and a store too with a D$
  assign storeStallD = execE.memRw[ctrlPkg::MemWriteBit] &
                       (ctrlD.memRw[ctrlPkg::MemReadBit] |
                        (ctrlD.memRw[ctrlPkg::MemWriteBit] & DcacheSupported));

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  assign execD.regWrite     = ctrlD.regWrite;
  assign execD.resultSrc    = ctrlD.resultSrc;
  assign execD.memRw        = ctrlD.memRw;
  assign execD.jump         = ctrlD.jump;
  assign execD.branch       = ctrlD.branch;
  assign execD.aluControl   = aluControlD;
  assign execD.aluSrcA      = ctrlD.aluSrcA;
  assign execD.aluSrcB      = ctrlD.aluSrcB;
  assign execD.aluResultSrc = ctrlD.aluResultSrc;
  assign execD.funct3       = funct3D;
  assign execD.instrValid   = instrValidD & ~ctrlD.illegal;  // Trap, not retire

  ctrlStageReg #(.PayloadT(ctrlPkg::execCtrlT)) ctrlRegE (
    .clk(clk), .arstN(arstN), .flush(flushE), .stall(stallE), .d(execD), .q(execE)
  );

  branchUnit branchUnitE (
    .flags(flagsE), .funct3(execE.funct3), .jump(execE.jump), .branch(execE.branch),
    .pcSrc(pcSrcE), .branchSigned(branchSignedE)
  );

  //////////////////////////////////////////////////
  // Memory and Writeback
  //////////////////////////////////////////////////

  assign memE.regWrite   = execE.regWrite;
  assign memE.resultSrc  = execE.resultSrc;
  assign memE.memRw      = execE.memRw;
  assign memE.funct3     = execE.funct3;      // Size and sign for the LSU
  assign memE.instrValid = execE.instrValid;

  ctrlStageReg #(.PayloadT(ctrlPkg::memCtrlT)) ctrlRegM (
    .clk(clk), .arstN(arstN), .flush(flushM), .stall(stallM), .d(memE), .q(memM)
  );

  assign wbM.regWrite  = memM.regWrite;
  assign wbM.resultSrc = memM.resultSrc;

  ctrlStageReg #(.PayloadT(ctrlPkg::wbCtrlT)) ctrlRegW (
    .clk(clk), .arstN(arstN), .flush(flushW), .stall(stallW), .d(wbM), .q(wbW)
  );

endmodule

`default_nettype wire

// ==== source/ctrlStageReg.sv ====
//////////////////////////////////////////////////
// Control pipeline register for one stage
// Holds on stall, clears on flush, flush wins.
// The payload type is set per instance
//////////////////////////////////////////////////

`default_nettype none

module ctrlStageReg #(
  parameter type PayloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    flush,                      // Clear on next edge
  input  logic    stall,                      // Hold current payload
  input  PayloadT d,
  output PayloadT q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;                                // All control inactive
    end else if (flush) begin
      q <= '0;                                // Bubble
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
common/ctrlPkg.sv
decode/instrDecoder.sv
decode/aluDecoder.sv
source/ctrlStageReg.sv
source/branchUnit.sv
source/controller.sv
verif/controllerTb.sv

// ==== verif/decodeModel.svh ====
//////////////////////////////////////////////////
// Reference model for the controller testbench
// Expected decode bundle, stage payloads, branch
// outcome. Included inside the testbench module
//////////////////////////////////////////////////

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Funct fields accepted by exact decoding
function automatic logic functLegal(logic [31:0] instr);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = instr[14:12];
  f7 = instr[31:25];
  case (instr[6:0])
    7'b0000011: return f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};  // Loads
    7'b0100011: return f3 inside {3'b000, 3'b001, 3'b010};                  // Stores
    7'b1100011: return !(f3 inside {3'b010, 3'b011});                       // Branches
    7'b1100111: return f3 == 3'b000;                                        // jalr
    7'b0010011: begin
      if (f3 == 3'b001)
        return f7 == 7'h00;                   // slli
      if (f3 == 3'b101)
        return f7 == 7'h00 || f7 == 7'h20;    // srli and srai
      return 1'b1;
    end
    7'b0110011: return f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'b000, 3'b101});
    default: return 1'b1;
  endcase
endfunction

// Decode bundle from the opcode table
function automatic ctrlPkg::decodeCtrlT decodeInstr(logic [31:0] instr);
  ctrlPkg::decodeCtrlT c;
  logic [11:0]         row;                   // {immSrc, regWrite, srcA, srcB, rd, wr,
  logic                known;                 //  branch, aluOp, jump, aluResultSrc}
  known = 1'b1;
  case (instr[6:0])
    7'b0000011: row = {ctrlPkg::iType, 9'b1_0_1_10_0_0_0_0};
    7'b0001111: row = {ctrlPkg::iType, 9'b0_0_0_00_0_0_0_0};  // fence
    7'b0010011: row = {ctrlPkg::iType, 9'b1_0_1_00_0_1_0_0};
    7'b0010111: row = {ctrlPkg::uType, 9'b1_1_1_00_0_0_0_0};
    7'b0100011: row = {ctrlPkg::sType, 9'b0_0_1_01_0_0_0_0};
    7'b0110011: row = {ctrlPkg::iType, 9'b1_0_0_00_0_1_0_0};
    7'b0110111: row = {ctrlPkg::uType, 9'b1_0_1_00_0_0_0_1};
    7'b1100011: row = {ctrlPkg::bType, 9'b0_1_1_00_1_0_0_0};
    7'b1100111: row = {ctrlPkg::iType, 9'b1_0_1_00_0_0_1_1};
    7'b1101111: row = {ctrlPkg::jType, 9'b1_1_1_00_0_0_1_1};
    default: begin
      row   = '0;
      known = 1'b0;
    end
  endcase
  c = '0;
  if (known && functLegal(instr)) begin
    c.immSrc = ctrlPkg::immSrcT'(row[11:9]);
    {c.regWrite, c.aluSrcA, c.aluSrcB, c.memRw} = row[8:4];
    {c.branch, c.aluOp, c.jump, c.aluResultSrc} = row[3:0];
    c.resultSrc = row[5] ? ctrlPkg::resMem : ctrlPkg::resAlu;  // Loads return memory data
    c.fence     = (instr[6:0] == 7'b0001111);
  end else begin
    c.illegal = 1'b1;
  end
  return c;
endfunction

// subArith for sub, sra/srai, slt/slti, sltu/sltiu
function automatic ctrlPkg::aluCtrlT aluControlFor(logic [31:0] instr, logic aluOp);
  logic sub;
  case (instr[14:12])
    3'b000:         sub = instr[30] & instr[5];  // addi never subtracts
    3'b101:         sub = instr[30];
    3'b010, 3'b011: sub = 1'b1;
    default:        sub = 1'b0;
  endcase
  return {1'b0, aluOp & sub, aluOp};
endfunction

function automatic ctrlPkg::execCtrlT execPayload(logic [31:0] instr, logic validD);
  ctrlPkg::decodeCtrlT d;
  d = decodeInstr(instr);
  return {d.regWrite, d.resultSrc, d.memRw, d.jump, d.branch, aluControlFor(instr, d.aluOp),
          d.aluSrcA, d.aluSrcB, d.aluResultSrc, instr[14:12], validD & !d.illegal};
endfunction

function automatic ctrlPkg::memCtrlT memPayload(ctrlPkg::execCtrlT e);
  return {e.regWrite, e.resultSrc, e.memRw, e.funct3, e.instrValid};
endfunction

function automatic ctrlPkg::wbCtrlT wbPayload(ctrlPkg::memCtrlT m);
  return {m.regWrite, m.resultSrc};
endfunction

// Returns {pcSrc, branchSigned}
function automatic logic [1:0] resolveBranch(logic [2:0] funct3, logic jump, logic branch,
                                             ctrlPkg::branchFlagsT flags);
  logic taken;
  case (funct3)
    3'b000:         taken = flags.eq;         // beq
    3'b001:         taken = !flags.eq;        // bne
    3'b100, 3'b110: taken = flags.lt;         // blt and bltu
    3'b101, 3'b111: taken = !flags.lt;        // bge and bgeu
    default:        taken = 1'b0;             // No branch decodes with this funct3
  endcase
  return {jump | (branch & taken), !(funct3 == 3'b110 || funct3 == 3'b111)};
endfunction

`endif

// ==== verif/controllerTb.sv ====
//////////////////////////////////////////////////
// Testbench for the RV32I controller
// Directed and LFSR instructions with random
// stall, flush and flags, checked by assertions
// against a model pipeline
//////////////////////////////////////////////////

`default_nettype none

module controllerTb;
  timeunit 1ns;
  timeprecision 100ps;

  `include "decodeModel.svh"

  localparam int ResetCycles   = 8;
  localparam int NumDirected   = 32;
  localparam int NumRandom     = 400;
  localparam int DrainCycles   = 4;           // Last instruction reaches W
  localparam int TimeoutCycles = ResetCycles + NumDirected + NumRandom + DrainCycles + 20;

  logic                 clk;
  logic                 arstN;
  logic                 stallD, flushD, stallE, flushE;
  logic                 stallM, flushM, stallW, flushW;
  logic [31:0]          instrD;
  ctrlPkg::branchFlagsT flagsE;
  ctrlPkg::immSrcT      immSrcD;
  logic                 illegalInstrD, jumpD, branchD, instrValidD, storeStallD;
  ctrlPkg::execCtrlT    execE;
  logic                 pcSrcE, branchSignedE;
  ctrlPkg::memCtrlT     memM;
  ctrlPkg::wbCtrlT      wbW;

  ctrlPkg::decodeCtrlT  expDec;               // Model of the D bundle
  logic                 expValidD;
  ctrlPkg::execCtrlT    expE;                 // Model pipeline
  ctrlPkg::memCtrlT     expM;
  ctrlPkg::wbCtrlT      expW;
  logic [1:0]           expBranch;            // {pcSrc, branchSigned}
  logic                 expStoreStall;
  logic [5:0]           decExpected, decActual;

  logic [31:0] lfsrState  = 32'h4fc4;
  int          cycleCount = 0;

  logic [31:0] directed [NumDirected] = '{
    32'h00012083, 32'h00010083, 32'h00013083, 32'h0ff0000f,  // lw lb bad-load fence
    32'h00108093, 32'h00109093, 32'h4010d093, 32'h40109093,  // addi slli srai bad-slli
    32'h0010a093, 32'h00001097, 32'h00112023, 32'h00112023,  // slti auipc sw sw
    32'h00012083, 32'h00113023, 32'h002080b3, 32'h402080b3,  // lw bad-store add sub
    32'h4020d0b3, 32'h0020b0b3, 32'h022080b3, 32'h402090b3,  // sra sltu mul bad-sll
    32'h000010b7, 32'h00208063, 32'h00209063, 32'h0020c063,  // lui beq bne blt
    32'h0020f063, 32'h0020a063, 32'h000100e7, 32'h000110e7,  // bgeu bad-br jalr bad-jalr
    32'h008000ef, 32'h00000073, 32'h00000000, 32'h0020f0b3   // jal ecall zero and
  };

  // Opcodes for random words with the common ones twice
  ctrlPkg::opcodeT opcodeTable [16] = '{
    ctrlPkg::opLoad, ctrlPkg::opMiscMem, ctrlPkg::opOpImm, ctrlPkg::opAuipc,
    ctrlPkg::opStore, ctrlPkg::opOp, ctrlPkg::opLui, ctrlPkg::opBranch,
    ctrlPkg::opJalr, ctrlPkg::opJal, ctrlPkg::opOp, ctrlPkg::opOpImm,
    ctrlPkg::opLoad, ctrlPkg::opStore, ctrlPkg::opBranch, ctrlPkg::opJal
  };

  controller dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus helpers and failure reporting
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randomBits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);        // Fresh bit from the feedback
      bits      = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  task automatic abortRun(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic reportMismatch(string testName, logic [31:0] expected, logic [31:0] actual);
    abortRun($sformatf("Fail %s expected 0x%0h actual 0x%0h", testName, expected, actual));
  endtask

  //////////////////////////////////////////////////
  // Model pipeline and checks
  //////////////////////////////////////////////////

  assign expDec        = decodeInstr(instrD);
  assign expBranch     = resolveBranch(expE.funct3, expE.jump, expE.branch, flagsE);
  assign expStoreStall = expE.memRw[0] & (expDec.memRw[1] | expDec.memRw[0]);  // With D$
  assign decExpected   = {expDec.immSrc, expDec.illegal, expDec.jump, expDec.branch};
  assign decActual     = {immSrcD, illegalInstrD, jumpD, branchD};

  // Flush clears and wins over stall
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      expValidD <= 1'b0;
      expE      <= '0;
      expM      <= '0;
      expW      <= '0;
    end else begin
      if (flushD)
        expValidD <= 1'b0;
      else if (!stallD)
        expValidD <= 1'b1;
      if (flushE)
        expE <= '0;
      else if (!stallE)
        expE <= execPayload(instrD, expValidD);
      if (flushM)
        expM <= '0;
      else if (!stallM)
        expM <= memPayload(expE);
      if (flushW)
        expW <= '0;
      else if (!stallW)
        expW <= wbPayload(expM);
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
      abortRun($sformatf("Timeout, no result after %0d cycles", cycleCount));
  end

  // Sampled mid-cycle while the inputs are stable
  decodeCheck: assert property (@(negedge clk) decActual == decExpected)
    else reportMismatch("decode", 32'(decExpected), 32'(decActual));
  validCheck: assert property (@(negedge clk) instrValidD == expValidD)
    else reportMismatch("instrValidD", 32'(expValidD), 32'(instrValidD));
  execCheck: assert property (@(negedge clk) execE == expE)
    else reportMismatch("execE", 32'(expE), 32'(execE));
  memCheck: assert property (@(negedge clk) memM == expM)
    else reportMismatch("memM", 32'(expM), 32'(memM));
  wbCheck: assert property (@(negedge clk) wbW == expW)
    else reportMismatch("wbW", 32'(expW), 32'(wbW));
  branchCheck: assert property (@(negedge clk) {pcSrcE, branchSignedE} == expBranch)
    else reportMismatch("branch", 32'(expBranch), 32'({pcSrcE, branchSignedE}));
  storeStallCheck: assert property (@(negedge clk) storeStallD == expStoreStall)
    else reportMismatch("storeStallD", 32'(expStoreStall), 32'(storeStallD));
  resetCheck: assert property (@(negedge clk)
    arstN || (execE == '0 && memM == '0 && wbW == '0 && !pcSrcE))
    else abortRun("Stage payloads or pcSrcE not cleared while in reset");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] word;
    logic [7:0]  hazard;                      // {stallD .. flushW}
    clk    = 1'b0;
    arstN  = 1'b0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    instrD = '0;
    flagsE = '0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    arstN = 1'b1;
    foreach (directed[i]) begin               // Clean pipeline without hazards
      instrD = directed[i];
      flagsE = 2'(randomBits(2));
      @(posedge clk);
      #1;
    end
    for (int n = 0; n < NumRandom; n++) begin
      word = randomBits(32);
      if (randomBits(3) != 32'd0)
        word[6:0] = opcodeTable[4'(randomBits(4))];  // Mostly known opcodes
      if (randomBits(2) != 32'd0)
        word[31:25] = randomBits(1) ? 7'h20 : 7'h00;  // Mostly legal funct7
      for (int k = 0; k < 8; k++)
        hazard[k] = (randomBits(3) == 32'd0);  // About one in eight
      instrD = word;
      flagsE = 2'(randomBits(2));
      {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = hazard;
      @(posedge clk);
      #1;
    end
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    repeat (DrainCycles) @(posedge clk);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
